//--- all.f
hw/core_pkg.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/pipeline.sv
verification/pipeline_checker.sv
verification/pipeline_tb.sv

//--- run.sh
#!/bin/sh
# builds the pipeline testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module pipeline_tb -f all.f -o pipeline_sim

output=$(./obj_dir/pipeline_sim)
echo "$output"

# the run passes only if the testbench printed its pass line
echo "$output" | grep -qx "Test OK"

//--- verification/pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb;

    localparam core_pkg::data_word_t RESET_ADDRESS = 32'h0000_0100;
    localparam int ENTRIES      = 27;
    localparam int MEMORY_WORDS = 64;
    localparam int PERIOD       = 100;

    typedef struct {
        string                name;
        core_pkg::data_word_t word;
        bit                   fetched;  // low for words in the shadow of a taken branch
        bit                   illegal;
        bit                   retires;
        core_pkg::reg_addr_t  dest;
        core_pkg::data_word_t value;
    } entry_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 fetch_valid;
    core_pkg::data_word_t fetch_instruction;
    logic                 fetch_acknowledge;
    logic                 fetch;
    core_pkg::data_word_t fetch_address;
    logic                 retire;
    core_pkg::reg_addr_t  retire_reg;
    core_pkg::data_word_t retire_data;
    logic                 illegal;
    logic                 done;
    int                   error_count;
    core_pkg::data_word_t word_index;
    entry_t               program_table [ENTRIES];
    core_pkg::data_word_t memory [MEMORY_WORDS];

    pipeline #(
        .RESET_ADDRESS ( RESET_ADDRESS )
    ) uut (
        .clk_i               ( clk               ),
        .rst_n_i             ( rst_n             ),
        .fetch_valid_i       ( fetch_valid       ),
        .fetch_instruction_i ( fetch_instruction ),
        .fetch_acknowledge_o ( fetch_acknowledge ),
        .fetch_o             ( fetch             ),
        .fetch_address_o     ( fetch_address     ),
        .retire_o            ( retire            ),
        .retire_reg_o        ( retire_reg        ),
        .retire_data_o       ( retire_data       ),
        .illegal_o           ( illegal           )
    );

    pipeline_checker #(
        .RESET_ADDRESS ( RESET_ADDRESS )
    ) u_checker (
        .clk_i               ( clk               ),
        .rst_n_i             ( rst_n             ),
        .fetch_i             ( fetch             ),
        .fetch_acknowledge_i ( fetch_acknowledge ),
        .fetch_address_i     ( fetch_address     ),
        .illegal_i           ( illegal           ),
        .retire_i            ( retire            ),
        .retire_reg_i        ( retire_reg        ),
        .retire_data_i       ( retire_data       ),
        .done_o              ( done              ),
        .error_count_o       ( error_count       )
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // x1 = 5 and x2 = -3 feed most of the ALU rows
    // the link values are absolute addresses for a program placed at 0x100
    task automatic fill_table();
        program_table[0]  = '{"addi_pos", 32'h00500093, 1'b1, 1'b0, 1'b1, 5'd1, 32'h00000005};
        program_table[1]  = '{"addi_neg", 32'hFFD00113, 1'b1, 1'b0, 1'b1, 5'd2, 32'hFFFFFFFD};
        program_table[2]  = '{"add", 32'h002081B3, 1'b1, 1'b0, 1'b1, 5'd3, 32'h00000002};
        program_table[3]  = '{"sub", 32'h40110233, 1'b1, 1'b0, 1'b1, 5'd4, 32'hFFFFFFF8};
        program_table[4]  = '{"and", 32'h0020F2B3, 1'b1, 1'b0, 1'b1, 5'd5, 32'h00000005};
        program_table[5]  = '{"or", 32'h0020E333, 1'b1, 1'b0, 1'b1, 5'd6, 32'hFFFFFFFD};
        program_table[6]  = '{"xor", 32'h0020C3B3, 1'b1, 1'b0, 1'b1, 5'd7, 32'hFFFFFFF8};
        program_table[7]  = '{"slt_true", 32'h00112433, 1'b1, 1'b0, 1'b1, 5'd8, 32'h00000001};
        program_table[8]  = '{"slt_false", 32'h0020A4B3, 1'b1, 1'b0, 1'b1, 5'd9, 32'h00000000};
        program_table[9]  = '{"slti_neg", 32'hFFF12513, 1'b1, 1'b0, 1'b1, 5'd10, 32'h00000001};
        program_table[10] = '{"andi_neg", 32'hFF027593, 1'b1, 1'b0, 1'b1, 5'd11, 32'hFFFFFFF0};
        program_table[11] = '{"ori", 32'h0F01E613, 1'b1, 1'b0, 1'b1, 5'd12, 32'h000000F2};
        program_table[12] = '{"xori_dep", 32'hFFF64693, 1'b1, 1'b0, 1'b1, 5'd13, 32'hFFFFFF0D};
        program_table[13] = '{"addi_x0", 32'h00708013, 1'b1, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[14] = '{"add_x0", 32'h00100733, 1'b1, 1'b0, 1'b1, 5'd14, 32'h00000005};
        program_table[15] = '{"beq_fall", 32'h00308463, 1'b1, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[16] = '{"bne_taken", 32'h00309663, 1'b1, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[17] = '{"bne_skip_a", 32'h00100793, 1'b0, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[18] = '{"bne_skip_b", 32'h00200793, 1'b0, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[19] = '{"beq_taken", 32'h00A40463, 1'b1, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[20] = '{"beq_skip", 32'h00300813, 1'b0, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[21] = '{"jal", 32'h00C008EF, 1'b1, 1'b0, 1'b1, 5'd17, 32'h00000158};
        program_table[22] = '{"jal_skip_a", 32'h00400913, 1'b0, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[23] = '{"jal_skip_b", 32'h00500913, 1'b0, 1'b0, 1'b0, 5'd0, 32'h00000000};
        program_table[24] = '{"illegal", 32'hFFFFFFFF, 1'b1, 1'b1, 1'b0, 5'd0, 32'h00000000};
        program_table[25] = '{"addi_link", 32'h00188993, 1'b1, 1'b0, 1'b1, 5'd19, 32'h00000159};
        program_table[26] = '{"self_loop", 32'h0000006F, 1'b1, 1'b0, 1'b0, 5'd0, 32'h00000000};
    endtask

    task automatic load_program();
        core_pkg::data_word_t address;
        // unused words hold illegal encodings that carry their own index
        for (int i = 0; i < MEMORY_WORDS; i++) begin
            memory[i] = {i[24:0], 7'h7F};
        end
        for (int i = 0; i < ENTRIES; i++) begin
            address   = RESET_ADDRESS + core_pkg::data_word_t'(i * 4);
            memory[i] = program_table[i].word;
            if (program_table[i].fetched) begin
                u_checker.expect_fetch(program_table[i].name, address, program_table[i].illegal);
            end
            if (program_table[i].retires) begin
                u_checker.expect_retire(program_table[i].name, program_table[i].dest,
                                        program_table[i].value);
            end
        end
    endtask

    // the memory answers the address shown since the last rising edge, with random gaps
    always @(negedge clk) begin
        word_index        = (fetch_address - RESET_ADDRESS) >> 2;
        fetch_instruction = memory[word_index[5:0]];
        fetch_valid       = fetch && ($urandom_range(3) != 0);
    end

    initial begin
        void'($urandom(32'h226e6afa));
        rst_n             = 1'b0;
        fetch_valid       = 1'b0;
        fetch_instruction = '0;
        fill_table();
        load_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait (done);
        repeat (10) @(posedge clk);  // room for a stray retire to show up
        u_checker.print_summary();
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (ENTRIES * 10 + 50) @(posedge clk);
        $display("timeout: the program did not finish within %0d clock cycles",
                 ENTRIES * 10 + 50);
        u_checker.print_summary();
        $display("Test FAILED");
        $finish;
    end

endmodule : pipeline_tb

`default_nettype wire

//--- verification/pipeline_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_checker #(
    parameter core_pkg::data_word_t RESET_ADDRESS = '0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 fetch_i,
    input  logic                 fetch_acknowledge_i,
    input  core_pkg::data_word_t fetch_address_i,
    input  logic                 illegal_i,
    input  logic                 retire_i,
    input  core_pkg::reg_addr_t  retire_reg_i,
    input  core_pkg::data_word_t retire_data_i,
    output logic                 done_o,
    output int                   error_count_o
);

    string                retire_names [$];
    core_pkg::reg_addr_t  retire_regs [$];
    core_pkg::data_word_t retire_values [$];
    string                fetch_names [$];
    core_pkg::data_word_t fetch_addresses [$];
    logic                 fetch_illegal [$];
    core_pkg::data_word_t final_address = '0;
    logic                 done = 1'b0;
    int                   check_count = 0;
    int                   error_count = 0;
    int                   reset_edges = 0;

    assign done_o        = done;
    assign error_count_o = error_count;

    task automatic expect_fetch(input string name, input core_pkg::data_word_t address,
                                input logic illegal);
        fetch_names.push_back(name);
        fetch_addresses.push_back(address);
        fetch_illegal.push_back(illegal);
        final_address = address;   // the table ends in a jump to itself
    endtask

    task automatic expect_retire(input string name, input core_pkg::reg_addr_t dest,
                                 input core_pkg::data_word_t value);
        retire_names.push_back(name);
        retire_regs.push_back(dest);
        retire_values.push_back(value);
    endtask

    task automatic compare(input string name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("error %s %s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    task automatic check_fetch();
        if (fetch_addresses.size() == 0) begin
            compare("self_loop", "fetch_address", final_address, fetch_address_i);
            compare("self_loop", "illegal", 32'd0, {31'd0, illegal_i});
        end else begin
            compare(fetch_names[0], "fetch_address", fetch_addresses[0], fetch_address_i);
            compare(fetch_names[0], "illegal", {31'd0, fetch_illegal[0]}, {31'd0, illegal_i});
            void'(fetch_names.pop_front());
            void'(fetch_addresses.pop_front());
            void'(fetch_illegal.pop_front());
        end
    endtask

    task automatic check_retire();
        if (retire_regs.size() == 0) begin
            error_count++;
            $display("unexpected retire of x%0d with %h after the last expected one",
                     retire_reg_i, retire_data_i);
        end else begin
            compare(retire_names[0], "retire_reg", {27'd0, retire_regs[0]},
                    {27'd0, retire_reg_i});
            compare(retire_names[0], "retire_data", retire_values[0], retire_data_i);
            void'(retire_names.pop_front());
            void'(retire_regs.pop_front());
            void'(retire_values.pop_front());
        end
    endtask

    task automatic print_summary();
        $display("checker: %0d checks, %0d errors, %0d retires and %0d fetches still expected",
                 check_count, error_count, retire_regs.size(), fetch_addresses.size());
    endtask

    // outputs are sampled on the rising edge, before the DUT registers update
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            if (reset_edges > 0) begin  // the first edge only loads the reset values
                compare("reset", "fetch", 32'd0, {31'd0, fetch_i});
                compare("reset", "fetch_address", RESET_ADDRESS, fetch_address_i);
                compare("reset", "strobes", 32'd0,
                        {29'd0, fetch_acknowledge_i, retire_i, illegal_i});
            end
            reset_edges++;
        end else begin
            if (fetch_acknowledge_i) begin
                check_fetch();
            end else if (illegal_i) begin
                error_count++;
                $display("illegal pulse at %h without a fetch acknowledge", fetch_address_i);
            end
            if (retire_i) begin
                check_retire();
            end
            done = (retire_regs.size() == 0) && (fetch_addresses.size() == 0);
        end
    end

endmodule : pipeline_checker

`default_nettype wire

//--- hw/pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline #(
    parameter core_pkg::data_word_t RESET_ADDRESS = '0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 fetch_valid_i,
    input  core_pkg::data_word_t fetch_instruction_i,
    output logic                 fetch_acknowledge_o,
    output logic                 fetch_o,
    output core_pkg::data_word_t fetch_address_o,
    output logic                 retire_o,
    output core_pkg::reg_addr_t  retire_reg_o,
    output core_pkg::data_word_t retire_data_o,
    output logic                 illegal_o
);

    core_pkg::exec_packet_t   decode_packet;
    core_pkg::exec_packet_t   execute_packet;
    core_pkg::result_packet_t execute_result;
    core_pkg::result_packet_t retire_result;
    core_pkg::redirect_t      redirect;
    logic                     issue;
    logic                     stall;

    decode_stage #(
        .RESET_ADDRESS ( RESET_ADDRESS )
    ) u_decode (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .fetch_valid_i       ( fetch_valid_i       ),
        .fetch_instruction_i ( fetch_instruction_i ),
        .fetch_acknowledge_o ( fetch_acknowledge_o ),
        .fetch_o             ( fetch_o             ),
        .fetch_address_o     ( fetch_address_o     ),
        .redirect_i          ( redirect            ),
        .execute_dest_i      ( execute_packet      ),
        .result_i            ( retire_result       ),
        .packet_o            ( decode_packet       ),
        .issue_o             ( issue               ),
        .stall_o             ( stall               ),
        .illegal_o           ( illegal_o           )
    );

    // a redirect flushes the slot, a stalled or missing word leaves a bubble
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            execute_packet.valid <= 1'b0;
        end else if (redirect.valid || !issue) begin
            execute_packet.valid <= 1'b0;
        end else if (!stall) begin
            execute_packet <= decode_packet;
        end
    end

    execute_stage u_execute (
        .packet_i   ( execute_packet ),
        .result_o   ( execute_result ),
        .redirect_o ( redirect       )
    );

    result_stage u_result (
        .clk_i         ( clk_i          ),
        .rst_n_i       ( rst_n_i        ),
        .result_i      ( execute_result ),
        .result_o      ( retire_result  ),
        .retire_o      ( retire_o       ),
        .retire_reg_o  ( retire_reg_o   ),
        .retire_data_o ( retire_data_o  )
    );

endmodule : pipeline

`default_nettype wire

//--- hw/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  core_pkg::result_packet_t result_i,
    output core_pkg::result_packet_t result_o,
    output logic                     retire_o,
    output core_pkg::reg_addr_t      retire_reg_o,
    output core_pkg::data_word_t     retire_data_o
);

    core_pkg::result_packet_t result_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_q <= '0;
        end else begin
            result_q <= result_i;
        end
    end

    // the same packet feeds the register file write and the decode interlock
    assign result_o = result_q;

    assign retire_o      = result_q.valid;
    assign retire_reg_o  = result_q.dest;
    assign retire_data_o = result_q.data;

    // validity is decided back in execute from the dest that decode chose
    no_x0_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_o |-> retire_reg_o != '0);

endmodule : result_stage

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  core_pkg::exec_packet_t   packet_i,
    output core_pkg::result_packet_t result_o,
    output core_pkg::redirect_t      redirect_o
);

    core_pkg::data_word_t alu_result;
    core_pkg::data_word_t link_address;
    logic                 signed_less;
    logic                 operands_equal;
    logic                 branch_taken;

    assign signed_less = $signed(packet_i.operand_a) < $signed(packet_i.operand_b);

    always_comb begin
        case (packet_i.alu_op)
            core_pkg::ALU_ADD: alu_result = packet_i.operand_a + packet_i.operand_b;
            core_pkg::ALU_SUB: alu_result = packet_i.operand_a - packet_i.operand_b;
            core_pkg::ALU_AND: alu_result = packet_i.operand_a & packet_i.operand_b;
            core_pkg::ALU_OR:  alu_result = packet_i.operand_a | packet_i.operand_b;
            core_pkg::ALU_XOR: alu_result = packet_i.operand_a ^ packet_i.operand_b;
            core_pkg::ALU_SLT: alu_result = {31'd0, signed_less};
            default:           alu_result = '0;
        endcase
    end

    // operand_b holds rs2 for R-type only, so branches compare against rs2_value
    assign operands_equal = packet_i.operand_a == packet_i.rs2_value;
    assign branch_taken   = packet_i.is_branch && (operands_equal != packet_i.branch_on_ne);

    assign link_address = packet_i.pc + 32'd4;

    // decode leaves dest at zero for branches and nops, so only real writes go on
    always_comb begin
        result_o.valid = packet_i.valid && packet_i.dest != '0;
        result_o.dest  = packet_i.dest;
        result_o.data  = packet_i.is_jal ? link_address : alu_result;
    end

    always_comb begin
        redirect_o.valid  = packet_i.valid && (branch_taken || packet_i.is_jal);
        redirect_o.target = packet_i.pc + packet_i.branch_offset;
    end

    // B and J offsets are only halfword aligned, and the pc comes from outside
    always_comb begin
        if (redirect_o.valid) begin
            target_aligned: assert (redirect_o.target[1:0] == 2'b00)
                else $error("redirect to unaligned target %h", redirect_o.target);
        end
    end

endmodule : execute_stage

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter core_pkg::data_word_t RESET_ADDRESS = '0
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_valid_i,
    input  core_pkg::data_word_t     fetch_instruction_i,
    output logic                     fetch_acknowledge_o,
    output logic                     fetch_o,
    output core_pkg::data_word_t     fetch_address_o,
    input  core_pkg::redirect_t      redirect_i,
    input  core_pkg::exec_packet_t   execute_dest_i,
    input  core_pkg::result_packet_t result_i,
    output core_pkg::exec_packet_t   packet_o,
    output logic                     issue_o,
    output logic                     stall_o,
    output logic                     illegal_o
);

    core_pkg::data_word_t  program_counter;
    logic                  fetch_enable;
    core_pkg::instr_word_u instr;
    core_pkg::data_word_t  rs1_value;
    core_pkg::data_word_t  rs2_value;
    logic                  legal;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  execute_busy;
    logic                  result_busy;
    logic                  hazard;
    logic                  accept;

    assign instr = fetch_instruction_i;

    register_file u_register_file (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .read_addr_a_i ( instr.r.rs1   ),
        .read_addr_b_i ( instr.r.rs2   ),
        .read_data_a_o ( rs1_value     ),
        .read_data_b_o ( rs2_value     ),
        .write_i       ( result_i      )
    );

    always_comb begin
        packet_o           = '0;
        packet_o.valid     = fetch_valid_i;
        packet_o.alu_op    = core_pkg::ALU_ADD;
        packet_o.operand_a = rs1_value;
        packet_o.operand_b = rs2_value;
        packet_o.rs2_value = rs2_value;
        packet_o.pc        = program_counter;
        legal    = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (instr.r.opcode)
            core_pkg::OPCODE_OP: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                packet_o.dest = instr.r.rd;
                case ({instr.r.funct7, instr.r.funct3})
                    {7'h00, 3'b000}: packet_o.alu_op = core_pkg::ALU_ADD;
                    {7'h20, 3'b000}: packet_o.alu_op = core_pkg::ALU_SUB;
                    {7'h00, 3'b111}: packet_o.alu_op = core_pkg::ALU_AND;
                    {7'h00, 3'b110}: packet_o.alu_op = core_pkg::ALU_OR;
                    {7'h00, 3'b100}: packet_o.alu_op = core_pkg::ALU_XOR;
                    {7'h00, 3'b010}: packet_o.alu_op = core_pkg::ALU_SLT;
                    default:         legal = 1'b0;
                endcase
            end
            core_pkg::OPCODE_OP_IMM: begin
                uses_rs1           = 1'b1;
                packet_o.dest      = instr.i.rd;
                packet_o.operand_b = {{20{instr.i.imm[11]}}, instr.i.imm};
                case (instr.i.funct3)
                    3'b000:  packet_o.alu_op = core_pkg::ALU_ADD;
                    3'b111:  packet_o.alu_op = core_pkg::ALU_AND;
                    3'b110:  packet_o.alu_op = core_pkg::ALU_OR;
                    3'b100:  packet_o.alu_op = core_pkg::ALU_XOR;
                    3'b010:  packet_o.alu_op = core_pkg::ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            core_pkg::OPCODE_BRANCH: begin
                uses_rs1               = 1'b1;
                uses_rs2               = 1'b1;
                packet_o.is_branch     = 1'b1;
                packet_o.branch_on_ne  = instr.b.funct3[0]; // BNE is funct3 001
                packet_o.branch_offset = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                                          instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                legal = (instr.b.funct3[2:1] == 2'b00);
            end
            core_pkg::OPCODE_JAL: begin
                packet_o.dest          = instr.j.rd;
                packet_o.is_jal        = 1'b1;
                packet_o.branch_offset = {{11{instr.j.imm_20}}, instr.j.imm_20,
                                          instr.j.imm_19_12, instr.j.imm_11,
                                          instr.j.imm_10_1, 1'b0};
            end
            default: legal = 1'b0;
        endcase
        // anything unsupported goes down the pipe as a nop
        if (!legal) begin
            uses_rs1               = 1'b0;
            uses_rs2               = 1'b0;
            packet_o.dest          = '0;
            packet_o.is_branch     = 1'b0;
            packet_o.is_jal        = 1'b0;
        end
    end

    // a source is blocked while either later stage still owes it a write
    assign execute_busy = execute_dest_i.valid && execute_dest_i.dest != '0;
    assign result_busy  = result_i.valid && result_i.dest != '0;

    assign hazard = (uses_rs1 && ((execute_busy && execute_dest_i.dest == instr.r.rs1) ||
                                  (result_busy && result_i.dest == instr.r.rs1))) ||
                    (uses_rs2 && ((execute_busy && execute_dest_i.dest == instr.r.rs2) ||
                                  (result_busy && result_i.dest == instr.r.rs2)));

    assign stall_o = fetch_enable && fetch_valid_i && hazard;
    assign accept  = fetch_enable && fetch_valid_i && !stall_o && !redirect_i.valid;

    assign fetch_o             = fetch_enable;
    assign fetch_address_o     = program_counter;
    assign fetch_acknowledge_o = accept;
    assign issue_o             = accept;
    assign illegal_o           = accept && !legal;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            program_counter <= RESET_ADDRESS;
            fetch_enable    <= 1'b0;
        end else begin
            fetch_enable <= 1'b1;
            if (redirect_i.valid) begin
                program_counter <= redirect_i.target;   // younger word is dropped
            end else if (accept) begin
                program_counter <= program_counter + 32'd4;
            end
        end
    end

    // a word held by the interlock keeps its address until it is taken
    stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_o && !redirect_i.valid |=> $stable(fetch_address_o));

endmodule : decode_stage

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  core_pkg::reg_addr_t      read_addr_a_i,
    input  core_pkg::reg_addr_t      read_addr_b_i,
    output core_pkg::data_word_t     read_data_a_o,
    output core_pkg::data_word_t     read_data_b_o,
    input  core_pkg::result_packet_t write_i
);

    // x0 has no storage, reads of it are forced to zero below
    core_pkg::data_word_t registers [1:31];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_i.valid && write_i.dest != '0) begin
            registers[write_i.dest] <= write_i.data;
        end
    end

    // no bypass, a value written this cycle is seen from the next one
    assign read_data_a_o = (read_addr_a_i == '0) ? '0 : registers[read_addr_a_i];
    assign read_data_b_o = (read_addr_b_i == '0) ? '0 : registers[read_addr_b_i];

endmodule : register_file

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] data_word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    // the four instruction layouts, all with the opcode in the low seven bits
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_format_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_format_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
        b_format_t b;
        j_format_t j;
    } instr_word_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef struct packed {
        logic       valid;
        alu_op_t    alu_op;
        data_word_t operand_a;
        data_word_t operand_b;     // immediate already selected for I-type
        data_word_t rs2_value;     // branch comparison only
        reg_addr_t  dest;          // zero means no write
        data_word_t pc;
        data_word_t branch_offset;
        logic       is_branch;
        logic       branch_on_ne;
        logic       is_jal;
    } exec_packet_t;

    typedef struct packed {
        logic       valid;
        reg_addr_t  dest;
        data_word_t data;
    } result_packet_t;

    typedef struct packed {
        logic       valid;
        data_word_t target;
    } redirect_t;

endpackage : core_pkg

`default_nettype wire
